// File: cfg_master_top.f
source/cfg_master_pkg.sv
source/cfg_apb_capture.sv
source/cfg_addr_decode.sv
source/cfg_req_router.sv
source/cfg_rsp_collect.sv
source/cfg_timeout.sv
source/cfg_master_top.sv
sim/cfg_master_checker.sv
sim/cfg_master_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the cfg_master testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

output=$(verilator --binary --timing --assert -Wno-fatal \
           --top-module cfg_master_tb -f cfg_master_top.f -o cfg_master_sim 2>&1 \
         && ./obj_dir/cfg_master_sim 2>&1)
echo "$output"

# The run counts as passed only if the testbench printed its pass line
echo "$output" | grep -q "=== PASS ===" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: sim/cfg_master_checker.sv
`timescale 1ns/1ps

module cfg_master_checker (
  input logic prim_gated_clk,
  input logic prim_gated_rst_b_sync,
  input logic cfg_disable_pslverr_timeout,
  input logic pready,
  input logic pslverr,
  input logic cfg_req_internal_write,
  input logic cfg_req_internal_read,
  input logic cfg_req_down_write,
  input logic cfg_req_down_read,
  input logic internal_v,
  input logic ring_v
);

  logic int_strobe;
  logic ring_strobe;

  assign int_strobe  = cfg_req_internal_write | cfg_req_internal_read;
  assign ring_strobe = cfg_req_down_write | cfg_req_down_read;

  // --------------------
  // APB response
  // --------------------

  // Each access completes with a single pready cycle
  pready_one_cycle: assert property (
    @(posedge prim_gated_clk) disable iff (!prim_gated_rst_b_sync)
    pready |=> !pready
  ) else $error("pready stayed high for more than one cycle");

  // Only timeouts raise pslverr, so a masked timeout never shows up
  pslverr_with_pready: assert property (
    @(posedge prim_gated_clk) disable iff (!prim_gated_rst_b_sync)
    pslverr |-> (pready && !cfg_disable_pslverr_timeout)
  ) else $error("pslverr high without pready or while timeout errors are masked");

  // --------------------
  // Request strobes
  // --------------------

  // A request never leaves while the other path still waits for its answer
  one_route_only: assert property (
    @(posedge prim_gated_clk) disable iff (!prim_gated_rst_b_sync)
    !((int_strobe && ring_v) || (ring_strobe && internal_v))
  ) else $error("request strobe while the other path is outstanding");

  // Strobes stay low for as long as reset is held
  quiet_in_reset: assert property (
    @(posedge prim_gated_clk)
    !prim_gated_rst_b_sync |-> !(int_strobe || ring_strobe)
  ) else $error("request strobe during reset");

endmodule

bind cfg_master_top cfg_master_checker u_checker (
  .prim_gated_clk              (prim_gated_clk),
  .prim_gated_rst_b_sync       (prim_gated_rst_b_sync),
  .cfg_disable_pslverr_timeout (cfg_disable_pslverr_timeout),
  .pready                      (pready),
  .pslverr                     (pslverr),
  .cfg_req_internal_write      (cfg_req_internal_write),
  .cfg_req_internal_read       (cfg_req_internal_read),
  .cfg_req_down_write          (cfg_req_down_write),
  .cfg_req_down_read           (cfg_req_down_read),
  .internal_v                  (internal_v),
  .ring_v                      (ring_v)
);

// File: sim/cfg_master_tb.sv
`timescale 1ns/1ps

module cfg_master_tb import cfg_master_pkg::*;;

  localparam logic [NODE_W-1:0] NODE_ID       = 4'h3;
  localparam int                TIMEOUT_VALUE = 12;
  localparam int                NUM_ENTRIES   = 13;
  // Cycles to wait for pready before giving up on an access
  localparam int                WAIT_LIMIT    = 60;

  // How the responder answers a request
  typedef enum logic [1:0] {act_ok, act_err, act_code, act_silent} rsp_act_e;
  // Port that the request is expected to leave on
  typedef enum logic [1:0] {route_none, route_int, route_ring} route_e;

  // One table row, exp_err is {decode, drop, slave access, slave timeout}
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic [DATA_W-1:0] wdata;
    rsp_act_e          act;
    logic [DATA_W-1:0] rdata;
    logic              run;
    logic              mask_tmo;
    route_e            route;
    cfg_mode_e         mode;
    logic [15:0]       target;
    logic [15:0]       offset;
    logic [DATA_W-1:0] exp_prdata;
    logic              exp_pslverr;
    logic [3:0]        exp_err;
  } stim_entry_t;

  logic              prim_gated_clk;
  logic              prim_gated_rst_b_sync;
  logic              pm_fsm_in_run;
  logic              flr_prep;
  logic              core_reset_done;
  logic              cfg_disable_pslverr_timeout;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [ADDR_W-1:0] paddr;
  logic [DATA_W-1:0] pwdata;
  logic              pready;
  logic [DATA_W-1:0] prdata;
  logic              pslverr;
  logic              cfg_req_internal_write;
  logic              cfg_req_internal_read;
  cfg_req_t          cfg_req_internal;
  logic              cfg_rsp_internal_ack;
  cfg_rsp_t          cfg_rsp_internal;
  logic              cfg_req_down_write;
  logic              cfg_req_down_read;
  cfg_req_t          cfg_req_down;
  logic              cfg_rsp_up_ack;
  cfg_rsp_t          cfg_rsp_up;
  logic              err_timeout;
  logic              err_cfg_protocol;
  logic              err_cfg_decode;
  logic              err_cfg_req_drop;
  logic              err_slv_access;
  logic              err_slv_timeout;

  stim_entry_t stim_table [NUM_ENTRIES];
  logic [31:0] rand_state;
  int          cur_entry;

  cfg_master_top #(
    .NODE_ID       (NODE_ID),
    .TIMEOUT_W     (8),
    .TIMEOUT_VALUE (TIMEOUT_VALUE)
  ) dut (.*);

  initial begin
    prim_gated_clk = 1'b0;
    forever #50 prim_gated_clk = ~prim_gated_clk;
  end

  // --------------------
  // Helpers
  // --------------------

  task automatic report_failure();
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on the first failure");
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error: time %0t ns, entry %0d, %s is %h, expected %h",
               $time, cur_entry, what, got, exp);
      report_failure();
    end
  endtask

  // Plain LCG, constants from the usual 32-bit table
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Responder latency of 1 to 5 cycles after the strobe
  function automatic int next_delay();
    rand_state = lcg_next(rand_state);
    return 1 + int'((rand_state >> 16) % 32'd5);
  endfunction

  function automatic cfg_rsp_t build_response(input stim_entry_t e);
    cfg_rsp_t r;
    r.rdata = (e.act == act_code) ? SLV_TIMEOUT_CODE : e.rdata;
    r.err   = (e.act == act_err) || (e.act == act_code);
    return r;
  endfunction

  // Node 3 is local, every other node sits on the ring
  task automatic fill_table();
    stim_table[0]  = '{32'h5951_5000, 1'b0, 32'h0, act_ok, 32'h1234_5678, 1'b1, 1'b0,
                       route_ring, mode_virtual, 16'h9500, 16'h0015, 32'h1234_5678, 1'b0, 4'b0000};
    stim_table[1]  = '{32'h6400_2af0, 1'b0, 32'h0, act_ok, 32'hcafe_0001, 1'b1, 1'b0,
                       route_ring, mode_register, 16'h4abc, 16'h0000, 32'hcafe_0001, 1'b0, 4'b0000};
    stim_table[2]  = '{32'h9e5a_48d0, 1'b0, 32'h0, act_ok, 32'h0bad_f00d, 1'b1, 1'b0,
                       route_ring, mode_memory, 16'he5a0, 16'h1234, 32'h0bad_f00d, 1'b0, 4'b0000};
    stim_table[3]  = '{32'h3600_0010, 1'b1, 32'hdead_beef, act_ok, 32'h0, 1'b1, 1'b0,
                       route_int, mode_memory, 16'h6000, 16'h0004, 32'h0, 1'b0, 4'b0000};
    // Illegal low bit in virtual mode, then an illegal middle bit in register mode
    stim_table[4]  = '{32'h5951_5004, 1'b0, 32'h0, act_ok, 32'h0, 1'b1, 1'b0,
                       route_none, mode_virtual, 16'h0, 16'h0, 32'h0, 1'b0, 4'b1000};
    stim_table[5]  = '{32'h3410_2af0, 1'b1, 32'h1111_2222, act_ok, 32'h0, 1'b1, 1'b0,
                       route_none, mode_register, 16'h0, 16'h0, 32'h0, 1'b0, 4'b1000};
    // Core not running, so the ring request is dropped
    stim_table[6]  = '{32'h5951_5000, 1'b0, 32'h0, act_ok, 32'h7777_0000, 1'b0, 1'b0,
                       route_none, mode_virtual, 16'h0, 16'h0, 32'h0, 1'b0, 4'b0100};
    stim_table[7]  = '{32'h9e5a_48d0, 1'b0, 32'h0, act_silent, 32'h0, 1'b1, 1'b0,
                       route_ring, mode_memory, 16'he5a0, 16'h1234, 32'h0, 1'b1, 4'b0000};
    stim_table[8]  = '{32'h3600_0010, 1'b0, 32'h0, act_silent, 32'h0, 1'b1, 1'b1,
                       route_int, mode_memory, 16'h6000, 16'h0004, 32'h0, 1'b0, 4'b0000};
    stim_table[9]  = '{32'h6400_2af0, 1'b0, 32'h0, act_err, 32'h0000_0042, 1'b1, 1'b0,
                       route_ring, mode_register, 16'h4abc, 16'h0000, 32'h0, 1'b0, 4'b0010};
    stim_table[10] = '{32'h9e5a_48d0, 1'b1, 32'h0000_abcd, act_code, 32'h0, 1'b1, 1'b0,
                       route_ring, mode_memory, 16'he5a0, 16'h1234, 32'h0, 1'b1, 4'b0011};
    stim_table[11] = '{32'h3c00_0004, 1'b0, 32'h0, act_ok, 32'h5555_aaaa, 1'b1, 1'b0,
                       route_int, mode_register, 16'hc001, 16'h0000, 32'h5555_aaaa, 1'b0, 4'b0000};
    stim_table[12] = '{32'h3c00_0004, 1'b0, 32'h0, act_code, 32'h0, 1'b1, 1'b1,
                       route_int, mode_register, 16'hc001, 16'h0000, 32'h0, 1'b0, 4'b0011};
  endtask

  // --------------------
  // One APB access
  // --------------------

  // Cycle counts are posedges after the edge that samples the access start
  task automatic run_entry(input int idx);
    stim_entry_t       e;
    cfg_req_t          got_req;
    route_e            got_route;
    logic              got_write;
    logic [DATA_W-1:0] got_prdata;
    logic              got_pslverr;
    logic [3:0]        seen_err;
    logic              seen_tmo;
    logic              seen_proto;
    logic              done;
    int                cnt;
    int                strobe_cnt;
    int                ack_at;
    int                ack_cnt;
    int                exp_lat;
    e           = stim_table[idx];
    cur_entry   = idx;
    got_req     = '0;
    got_route   = route_none;
    got_write   = 1'b0;
    got_prdata  = '0;
    got_pslverr = 1'b0;
    seen_err    = '0;
    seen_tmo    = 1'b0;
    seen_proto  = 1'b0;
    done        = 1'b0;
    strobe_cnt  = -1;
    ack_at      = -1;
    ack_cnt     = -1;

    // Setup phase, then the access phase on the next falling edge
    pm_fsm_in_run               = e.run;
    cfg_disable_pslverr_timeout = e.mask_tmo;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = e.write;
    paddr   = e.addr;
    pwdata  = e.wdata;
    @(negedge prim_gated_clk);
    penable = 1'b1;
    cnt     = -1;

    while (!done) begin
      @(negedge prim_gated_clk);
      cnt++;
      if (cfg_req_down_write || cfg_req_down_read) begin
        got_route  = route_ring;
        got_req    = cfg_req_down;
        got_write  = cfg_req_down_write;
        strobe_cnt = cnt;
      end else if (cfg_req_internal_write || cfg_req_internal_read) begin
        got_route  = route_int;
        got_req    = cfg_req_internal;
        got_write  = cfg_req_internal_write;
        strobe_cnt = cnt;
      end
      if ((strobe_cnt == cnt) && (e.act != act_silent)) begin
        ack_at = cnt + next_delay();
      end
      seen_err   = seen_err | {err_cfg_decode, err_cfg_req_drop, err_slv_access, err_slv_timeout};
      seen_tmo   = seen_tmo | err_timeout;
      seen_proto = seen_proto | err_cfg_protocol;

      // Responder acks for exactly one cycle on the port the request used
      cfg_rsp_internal_ack = 1'b0;
      cfg_rsp_internal     = '0;
      cfg_rsp_up_ack       = 1'b0;
      cfg_rsp_up           = '0;
      if (cnt == ack_at) begin
        ack_cnt = cnt;
        if (got_route == route_ring) begin
          cfg_rsp_up_ack = 1'b1;
          cfg_rsp_up     = build_response(e);
        end else begin
          cfg_rsp_internal_ack = 1'b1;
          cfg_rsp_internal     = build_response(e);
        end
      end

      if (pready) begin
        got_prdata  = prdata;
        got_pslverr = pslverr;
        done        = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
      end else if (cnt >= WAIT_LIMIT) begin
        $display("Timeout: entry %0d got no pready within %0d cycles", idx, WAIT_LIMIT);
        report_failure();
      end
    end

    check_value("route", got_route, e.route);
    if (e.route != route_none) begin
      check_value("strobe cycle", strobe_cnt, 2);
      check_value("strobe write", got_write, e.write);
      check_value("req node", got_req.node, e.addr[31:28]);
      check_value("req mode", got_req.mode, e.mode);
      check_value("req target", got_req.target, e.target);
      check_value("req offset", got_req.offset, e.offset);
      check_value("req wdata", got_req.wdata, e.write ? e.wdata : 32'h0);
      check_value("req decode_err", got_req.decode_err, 1'b0);
    end

    // Drops finish three cycles in, the timer after its full count
    if (e.route == route_none) begin
      exp_lat = 3;
    end else if (e.act == act_silent) begin
      exp_lat = TIMEOUT_VALUE + 3;
    end else begin
      exp_lat = ack_cnt + 2;
    end
    check_value("pready cycle", cnt, exp_lat);
    check_value("prdata", got_prdata, e.exp_prdata);
    check_value("pslverr", got_pslverr, e.exp_pslverr);
    check_value("error flags", seen_err, e.exp_err);
    check_value("err_timeout", seen_tmo, e.act == act_silent);
    check_value("err_cfg_protocol", seen_proto, 1'b0);

    // Idle gap so pulses of one access cannot leak into the next
    repeat (3) @(negedge prim_gated_clk);
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    prim_gated_rst_b_sync       = 1'b0;
    pm_fsm_in_run               = 1'b1;
    flr_prep                    = 1'b0;
    core_reset_done             = 1'b1;
    cfg_disable_pslverr_timeout = 1'b0;
    psel                        = 1'b0;
    penable                     = 1'b0;
    pwrite                      = 1'b0;
    paddr                       = '0;
    pwdata                      = '0;
    cfg_rsp_internal_ack        = 1'b0;
    cfg_rsp_internal            = '0;
    cfg_rsp_up_ack              = 1'b0;
    cfg_rsp_up                  = '0;
    rand_state                  = 32'he457bcdc;
    cur_entry                   = -1;
    fill_table();

    repeat (5) @(posedge prim_gated_clk);
    @(negedge prim_gated_clk);
    // Outputs must be quiet while reset is held
    check_value("pready in reset", pready, 1'b0);
    check_value("pslverr in reset", pslverr, 1'b0);
    check_value("prdata in reset", prdata, 32'h0);
    check_value("strobes in reset", {cfg_req_internal_write, cfg_req_internal_read,
                cfg_req_down_write, cfg_req_down_read}, 4'b0);
    check_value("errors in reset", {err_timeout, err_cfg_protocol, err_cfg_decode,
                err_cfg_req_drop, err_slv_access, err_slv_timeout}, 6'b0);
    prim_gated_rst_b_sync = 1'b1;
    repeat (2) @(negedge prim_gated_clk);

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      run_entry(i);
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: source/cfg_addr_decode.sv
`timescale 1ns/1ps

module cfg_addr_decode import cfg_master_pkg::*; (
  input  logic              prim_gated_clk,
  input  logic              prim_gated_rst_b_sync,
  input  logic              access,
  input  logic              acc_write,
  input  logic [ADDR_W-1:0] acc_addr,
  input  logic [DATA_W-1:0] acc_wdata,
  output logic              req_write,
  output logic              req_read,
  output cfg_req_t          req
);

  cfg_req_t req_nxt;

  // --------------------
  // Address decode
  // --------------------

  always_comb begin
    req_nxt            = '0;
    req_nxt.node       = acc_addr[31:28];
    // Reads carry no write data
    req_nxt.wdata      = acc_write ? acc_wdata : '0;

    if (acc_addr[26] == 1'b0) begin
      // Virtual mode, low bits below the offset must be zero
      req_nxt.mode       = mode_virtual;
      req_nxt.target     = {acc_addr[27], acc_addr[26], acc_addr[25:19], 7'd0};
      req_nxt.offset     = {9'd0, acc_addr[18:12]};
      req_nxt.decode_err = |acc_addr[11:2];
    end else if (acc_addr[26:25] == 2'b10) begin
      // Register mode has no offset
      // The middle bits between target fields are unused
      req_nxt.mode       = mode_register;
      req_nxt.target     = {acc_addr[27:25], acc_addr[14:2]};
      req_nxt.offset     = '0;
      req_nxt.decode_err = |acc_addr[24:15];
    end else begin
      // Memory mode decodes every bit, so it never fails
      req_nxt.mode       = mode_memory;
      req_nxt.target     = {acc_addr[27:16], 4'd0};
      req_nxt.offset     = {2'd0, acc_addr[15:2]};
      req_nxt.decode_err = 1'b0;
    end
  end

  // --------------------
  // Request register
  // --------------------

  always_ff @(posedge prim_gated_clk or negedge prim_gated_rst_b_sync) begin
    if (~prim_gated_rst_b_sync) begin
      req_write <= 1'b0;
      req_read  <= 1'b0;
    end else begin
      req_write <= access & acc_write;
      req_read  <= access & ~acc_write;
    end
  end

  // The request word is qualified by the pulses above
  always_ff @(posedge prim_gated_clk) begin
    if (access) begin
      req <= req_nxt;
    end
  end

endmodule

// File: source/cfg_apb_capture.sv
`timescale 1ns/1ps

module cfg_apb_capture import cfg_master_pkg::*; (
  input  logic              prim_gated_clk,
  input  logic              prim_gated_rst_b_sync,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  logic [DATA_W-1:0] pwdata,
  input  logic              rsp_ready,
  input  logic [DATA_W-1:0] rsp_rdata,
  input  logic              rsp_slverr,
  input  logic              rsp_clr_data,
  output logic              access,
  output logic              acc_write,
  output logic [ADDR_W-1:0] acc_addr,
  output logic [DATA_W-1:0] acc_wdata,
  output logic              abort,
  output logic              err_cfg_protocol,
  output logic              pready,
  output logic [DATA_W-1:0] prdata,
  output logic              pslverr
);

  logic              psel_f;
  logic              penable_f;
  logic              pselenb;
  logic              pselenb_f;
  logic              pwrite_f;
  logic              abort_f;
  logic              pready_f;
  logic              pslverr_f;
  logic              clr_f;
  logic              inflight_f;
  logic              protocol_f;
  logic [ADDR_W-1:0] paddr_f;
  logic [DATA_W-1:0] pwdata_f;
  logic [DATA_W-1:0] prdata_f;

  // Access phase starts on the first cycle with penable high
  assign pselenb = psel & penable & ~penable_f;

  // Requestor left before it saw pready
  assign abort = ~psel & psel_f & ~pready_f;

  always_ff @(posedge prim_gated_clk or negedge prim_gated_rst_b_sync) begin
    if (~prim_gated_rst_b_sync) begin
      psel_f     <= 1'b0;
      penable_f  <= 1'b0;
      pselenb_f  <= 1'b0;
      pwrite_f   <= 1'b0;
      abort_f    <= 1'b0;
      pready_f   <= 1'b0;
      pslverr_f  <= 1'b0;
      clr_f      <= 1'b0;
      inflight_f <= 1'b0;
      protocol_f <= 1'b0;
    end else begin
      psel_f     <= psel;
      penable_f  <= penable;
      pselenb_f  <= pselenb;
      pwrite_f   <= pselenb ? pwrite : pwrite_f;
      // The abort stays pending until the next access starts
      abort_f    <= (abort_f | abort) & ~pselenb;
      pready_f   <= rsp_ready;
      pslverr_f  <= rsp_slverr;
      clr_f      <= rsp_clr_data;
      // An access stays in flight until its response arrives or it is aborted
      inflight_f <= pselenb | (inflight_f & ~(rsp_ready | abort));
      // A new start while the old access is still in flight overlaps it
      protocol_f <= pselenb & inflight_f;
    end
  end

  // Captured address and write data for the decoder, read data for the response
  always_ff @(posedge prim_gated_clk) begin
    if (pselenb) begin
      paddr_f <= paddr;
    end
    if (pselenb & pwrite) begin
      pwdata_f <= pwdata;
    end
    prdata_f <= rsp_rdata;
  end

  assign access           = pselenb_f;
  assign acc_write        = pwrite_f;
  assign acc_addr         = paddr_f;
  assign acc_wdata        = pwdata_f;
  assign err_cfg_protocol = protocol_f;

  // --------------------
  // APB response
  // --------------------

  // Nothing goes back to a requestor that has already aborted
  assign pready  = pready_f & ~abort_f;
  assign prdata  = (pready & ~clr_f) ? prdata_f : '0;
  assign pslverr = pready & pslverr_f;

endmodule

// File: source/cfg_master_pkg.sv
package cfg_master_pkg;

  // --------------------
  // Widths
  // --------------------

  // APB address and data widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Width of the node field at the top of the address
  localparam int NODE_W = 4;

  // Read data a slave returns together with err when its own access timed out
  localparam logic [DATA_W-1:0] SLV_TIMEOUT_CODE = 32'haaaabeef;

  // --------------------
  // Request and response
  // --------------------

  // Address decode mode, value 1 is not used
  typedef enum logic [1:0] {
    mode_virtual  = 2'd0,
    mode_register = 2'd2,
    mode_memory   = 2'd3
  } cfg_mode_e;

  // Request as it travels to the internal block or down the ring
  typedef struct packed {
    logic [NODE_W-1:0] node;
    cfg_mode_e         mode;
    logic [15:0]       target;
    logic [15:0]       offset;
    logic [DATA_W-1:0] wdata;
    // Set when unused address bits were not zero
    logic              decode_err;
  } cfg_req_t;

  // Response returned with a one-cycle ack
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } cfg_rsp_t;

endpackage

// File: source/cfg_master_top.sv
`timescale 1ns/1ps

module cfg_master_top import cfg_master_pkg::*; #(
  parameter logic [NODE_W-1:0] NODE_ID       = '0,
  parameter int                TIMEOUT_W     = 8,
  parameter int                TIMEOUT_VALUE = 16
) (
  input  logic              prim_gated_clk,
  input  logic              prim_gated_rst_b_sync,
  input  logic              pm_fsm_in_run,
  input  logic              flr_prep,
  input  logic              core_reset_done,
  input  logic              cfg_disable_pslverr_timeout,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  logic [DATA_W-1:0] pwdata,
  output logic              pready,
  output logic [DATA_W-1:0] prdata,
  output logic              pslverr,
  output logic              cfg_req_internal_write,
  output logic              cfg_req_internal_read,
  output cfg_req_t          cfg_req_internal,
  input  logic              cfg_rsp_internal_ack,
  input  cfg_rsp_t          cfg_rsp_internal,
  output logic              cfg_req_down_write,
  output logic              cfg_req_down_read,
  output cfg_req_t          cfg_req_down,
  input  logic              cfg_rsp_up_ack,
  input  cfg_rsp_t          cfg_rsp_up,
  output logic              err_timeout,
  output logic              err_cfg_protocol,
  output logic              err_cfg_decode,
  output logic              err_cfg_req_drop,
  output logic              err_slv_access,
  output logic              err_slv_timeout
);

  logic              access;
  logic              acc_write;
  logic [ADDR_W-1:0] acc_addr;
  logic [DATA_W-1:0] acc_wdata;
  logic              abort;
  logic              req_write;
  logic              req_read;
  cfg_req_t          req;
  logic              internal_v;
  logic              ring_v;
  logic              internal_drop;
  logic              ring_drop;
  logic              internal_ready;
  logic              ring_ready;
  logic [DATA_W-1:0] rsp_rdata;
  logic              rsp_clr_data;
  logic              rsp_ready;
  logic              rsp_slverr;
  logic              req_start;

  // --------------------
  // Completion
  // --------------------

  // Any way a request can end produces the pready
  assign rsp_ready  = internal_ready | ring_ready | internal_drop | ring_drop | err_timeout;
  // Timeouts, ours or the slave's, may be kept off pslverr
  assign rsp_slverr = (err_timeout | err_slv_timeout) & ~cfg_disable_pslverr_timeout;
  // Only a request that really left starts the timer
  assign req_start  = cfg_req_internal_write | cfg_req_internal_read |
                      cfg_req_down_write | cfg_req_down_read;

  cfg_apb_capture u_capture (
    .prim_gated_clk, .prim_gated_rst_b_sync,
    .psel, .penable, .pwrite, .paddr, .pwdata,
    .rsp_ready, .rsp_rdata, .rsp_slverr, .rsp_clr_data,
    .access, .acc_write, .acc_addr, .acc_wdata, .abort,
    .err_cfg_protocol, .pready, .prdata, .pslverr
  );

  cfg_addr_decode u_decode (
    .prim_gated_clk, .prim_gated_rst_b_sync,
    .access, .acc_write, .acc_addr, .acc_wdata,
    .req_write, .req_read, .req
  );

  cfg_req_router #(
    .NODE_ID (NODE_ID)
  ) u_router (
    .prim_gated_clk, .prim_gated_rst_b_sync,
    .req_write, .req_read, .req, .abort,
    .ring_ready, .internal_ready, .err_timeout,
    .pm_fsm_in_run, .flr_prep, .core_reset_done,
    .cfg_req_internal_write, .cfg_req_internal_read, .cfg_req_internal,
    .cfg_req_down_write, .cfg_req_down_read, .cfg_req_down,
    .internal_v, .ring_v, .internal_drop, .ring_drop,
    .err_cfg_decode, .err_cfg_req_drop
  );

  cfg_rsp_collect u_collect (
    .prim_gated_clk, .prim_gated_rst_b_sync,
    .cfg_rsp_internal_ack, .cfg_rsp_internal, .cfg_rsp_up_ack, .cfg_rsp_up,
    .internal_v, .ring_v, .internal_ready, .ring_ready,
    .rsp_rdata, .err_slv_access, .err_slv_timeout, .rsp_clr_data
  );

  // A drop also ends the path so the timer does not fire on it
  cfg_timeout #(
    .TIMEOUT_W     (TIMEOUT_W),
    .TIMEOUT_VALUE (TIMEOUT_VALUE)
  ) u_timeout (
    .prim_gated_clk, .prim_gated_rst_b_sync,
    .req_start, .ring_v, .internal_v,
    .ring_ready     (ring_ready | ring_drop),
    .internal_ready (internal_ready | internal_drop),
    .abort, .err_timeout
  );

endmodule

// File: source/cfg_req_router.sv
`timescale 1ns/1ps

module cfg_req_router import cfg_master_pkg::*; #(
  parameter logic [NODE_W-1:0] NODE_ID = '0
) (
  input  logic     prim_gated_clk,
  input  logic     prim_gated_rst_b_sync,
  input  logic     req_write,
  input  logic     req_read,
  input  cfg_req_t req,
  input  logic     abort,
  input  logic     ring_ready,
  input  logic     internal_ready,
  input  logic     err_timeout,
  input  logic     pm_fsm_in_run,
  input  logic     flr_prep,
  input  logic     core_reset_done,
  output logic     cfg_req_internal_write,
  output logic     cfg_req_internal_read,
  output cfg_req_t cfg_req_internal,
  output logic     cfg_req_down_write,
  output logic     cfg_req_down_read,
  output cfg_req_t cfg_req_down,
  output logic     internal_v,
  output logic     ring_v,
  output logic     internal_drop,
  output logic     ring_drop,
  output logic     err_cfg_decode,
  output logic     err_cfg_req_drop
);

  logic     is_internal;
  logic     req_any;
  logic     int_write_f;
  logic     int_read_f;
  logic     down_write_f;
  logic     down_read_f;
  cfg_req_t int_req_f;
  cfg_req_t down_req_f;
  logic     int_bad;
  logic     down_bad;

  // Own node ID selects the local register block, anything else goes on the ring
  assign is_internal = (req.node == NODE_ID);
  assign req_any     = req_write | req_read;

  always_ff @(posedge prim_gated_clk or negedge prim_gated_rst_b_sync) begin
    if (~prim_gated_rst_b_sync) begin
      int_write_f  <= 1'b0;
      int_read_f   <= 1'b0;
      down_write_f <= 1'b0;
      down_read_f  <= 1'b0;
      int_req_f    <= '0;
      down_req_f   <= '0;
      internal_v   <= 1'b0;
      ring_v       <= 1'b0;
    end else begin
      int_write_f  <= req_write & is_internal;
      int_read_f   <= req_read & is_internal;
      down_write_f <= req_write & ~is_internal;
      down_read_f  <= req_read & ~is_internal;
      // Request words are zero outside their strobe cycle
      int_req_f    <= (req_any & is_internal) ? req : '0;
      down_req_f   <= (req_any & ~is_internal) ? req : '0;
      // Outstanding flags run from launch until the path completes
      internal_v   <= (req_any & is_internal & ~abort) |
                      (internal_v & ~(abort | internal_ready | err_timeout | internal_drop));
      ring_v       <= (req_any & ~is_internal & ~abort) |
                      (ring_v & ~(abort | ring_ready | err_timeout | ring_drop));
    end
  end

  // --------------------
  // Drop decision
  // --------------------

  // The ring is off limits until the core runs and has left reset and FLR
  assign int_bad  = int_req_f.decode_err;
  assign down_bad = down_req_f.decode_err | ~pm_fsm_in_run | flr_prep | ~core_reset_done;

  assign internal_drop = (int_write_f | int_read_f) & int_bad;
  assign ring_drop     = (down_write_f | down_read_f) & down_bad;

  assign cfg_req_internal_write = int_write_f & ~int_bad;
  assign cfg_req_internal_read  = int_read_f & ~int_bad;
  assign cfg_req_internal       = int_bad ? '0 : int_req_f;
  assign cfg_req_down_write     = down_write_f & ~down_bad;
  assign cfg_req_down_read      = down_read_f & ~down_bad;
  assign cfg_req_down           = down_bad ? '0 : down_req_f;

  // Error flags line up with the pready of the dropped request
  always_ff @(posedge prim_gated_clk or negedge prim_gated_rst_b_sync) begin
    if (~prim_gated_rst_b_sync) begin
      err_cfg_decode   <= 1'b0;
      err_cfg_req_drop <= 1'b0;
    end else begin
      err_cfg_decode   <= (internal_drop & int_req_f.decode_err) |
                          (ring_drop & down_req_f.decode_err);
      // A decode error is reported as such, not as a drop
      err_cfg_req_drop <= ring_drop & ~down_req_f.decode_err;
    end
  end

endmodule

// File: source/cfg_rsp_collect.sv
`timescale 1ns/1ps

module cfg_rsp_collect import cfg_master_pkg::*; (
  input  logic              prim_gated_clk,
  input  logic              prim_gated_rst_b_sync,
  input  logic              cfg_rsp_internal_ack,
  input  cfg_rsp_t          cfg_rsp_internal,
  input  logic              cfg_rsp_up_ack,
  input  cfg_rsp_t          cfg_rsp_up,
  input  logic              internal_v,
  input  logic              ring_v,
  output logic              internal_ready,
  output logic              ring_ready,
  output logic [DATA_W-1:0] rsp_rdata,
  output logic              err_slv_access,
  output logic              err_slv_timeout,
  output logic              rsp_clr_data
);

  logic     int_ack_f;
  logic     up_ack_f;
  cfg_rsp_t int_rsp_f;
  cfg_rsp_t up_rsp_f;
  cfg_rsp_t sel_rsp;

  // The ack can land on any cycle, so both ports are flopped every cycle
  always_ff @(posedge prim_gated_clk or negedge prim_gated_rst_b_sync) begin
    if (~prim_gated_rst_b_sync) begin
      int_ack_f <= 1'b0;
      up_ack_f  <= 1'b0;
    end else begin
      int_ack_f <= cfg_rsp_internal_ack;
      up_ack_f  <= cfg_rsp_up_ack;
    end
  end

  always_ff @(posedge prim_gated_clk) begin
    int_rsp_f <= cfg_rsp_internal;
    up_rsp_f  <= cfg_rsp_up;
  end

  // An ack only counts on the path that has a request outstanding
  assign internal_ready = int_ack_f & internal_v;
  assign ring_ready     = up_ack_f & ring_v;

  // --------------------
  // Response select
  // --------------------

  always_comb begin
    sel_rsp = '0;
    if (ring_ready) begin
      // Ring response takes priority
      sel_rsp = up_rsp_f;
    end else if (internal_ready) begin
      sel_rsp = int_rsp_f;
    end
  end

  assign rsp_rdata       = sel_rsp.rdata;
  assign err_slv_access  = sel_rsp.err;
  // A slave that timed out says so through a fixed rdata code
  assign err_slv_timeout = sel_rsp.err & (sel_rsp.rdata == SLV_TIMEOUT_CODE);
  // Error codes in rdata are never passed to the requestor
  assign rsp_clr_data    = sel_rsp.err;

endmodule

// File: source/cfg_timeout.sv
`timescale 1ns/1ps

module cfg_timeout #(
  parameter int TIMEOUT_W     = 8,
  parameter int TIMEOUT_VALUE = 16
) (
  input  logic prim_gated_clk,
  input  logic prim_gated_rst_b_sync,
  input  logic req_start,
  input  logic ring_v,
  input  logic internal_v,
  input  logic ring_ready,
  input  logic internal_ready,
  input  logic abort,
  output logic err_timeout
);

  localparam logic [TIMEOUT_W-1:0] TIMEOUT_LOAD = TIMEOUT_W'(TIMEOUT_VALUE - 1);

  logic [TIMEOUT_W-1:0] count_f;
  logic [TIMEOUT_W-1:0] count_nxt;
  logic                 busy;

  assign busy = ring_v | internal_v;

  // Priority is load, then hold, then alarm, then count
  always_comb begin
    count_nxt   = count_f;
    err_timeout = 1'b0;
    if (req_start) begin
      count_nxt = TIMEOUT_LOAD;
    end else if (ring_ready | internal_ready | abort) begin
      // Request finished, keep the count where it stopped
      count_nxt = count_f;
    end else if (busy & (count_f == '0)) begin
      count_nxt   = TIMEOUT_LOAD;
      err_timeout = 1'b1;
    end else if (busy) begin
      count_nxt = count_f - 1'b1;
    end
  end

  always_ff @(posedge prim_gated_clk or negedge prim_gated_rst_b_sync) begin
    if (~prim_gated_rst_b_sync) begin
      count_f <= TIMEOUT_LOAD;
    end else begin
      count_f <= count_nxt;
    end
  end

endmodule
